//--- logic/mmix_decode_pkg.sv
// shared widths, encodings and opcode constants for the dispatch decoder
// push/pop are not decoded, so ring offset O and stack pointer S stay at zero
// and local register n always sits in ring slot n
// op_class_e is 5 bits, spec_kind_e is 2 bits; both feed the output stage as is

`default_nettype none

package mmix_decode_pkg;

	typedef logic [31:0] inst_word_t; // op, x, y, z bytes
	typedef logic [63:0] addr_t; // location, immediates, ring slots
	typedef logic [7:0]  reg_num_t; // register number or X/Y/Z/G/L field
	typedef logic [7:0]  op_flags_t; // operand flag byte, see FLAG_*

	// local register ring
	localparam int RING_SIZE = 256;

	// bit positions in op_flags_t
	localparam int FLAG_Z_IMM  = 0; // Z is an immediate
	localparam int FLAG_Z_REG  = 1; // $Z is a source
	localparam int FLAG_Y_IMM  = 2; // Y is an immediate
	localparam int FLAG_Y_REG  = 3; // $Y is a source
	localparam int FLAG_X_SRC  = 4; // $X is a source
	localparam int FLAG_X_DEST = 5; // $X is written
	localparam int FLAG_REL    = 6; // YZ or XYZ is a relative address

	// opcode bases
	localparam logic [7:0] OP_WYDE_BASE = 8'hE0; // SETH .. ANDNL
	localparam logic [7:0] OP_JMP       = 8'hF0; // JMP, JMPB at +1
	localparam logic [7:0] OP_BR_FIRST  = 8'h40; // BN
	localparam logic [7:0] OP_BR_LAST   = 8'h5F; // PBEVB

	// internal operation class handed to the execution units
	typedef enum logic [4:0] {
		cls_trap,
		cls_add,
		cls_addu,
		cls_sub,
		cls_subu,
		cls_cmp,
		cls_cmpu,
		cls_shl,
		cls_shr,
		cls_br,
		cls_pbr,
		cls_cset,
		cls_logic,
		cls_set,
		cls_wyde,
		cls_jmp,
		cls_incrl // interim, widens the local window by one
	} op_class_e;

	// what a specifier value means
	typedef enum logic [1:0] {
		kind_none,   // operand not used, value is zero
		kind_imm,    // value is the operand itself
		kind_global, // value is a global register number
		kind_local   // value is a local ring slot
	} spec_kind_e;

endpackage

`default_nettype wire

//--- logic/opcode_table.sv
// opcode to operation class and operand flags, purely combinational
// only integer add/sub, compare, shifts, branches, conditional set, bitwise
// logic, wyde immediates and JMP are supported; anything else comes out as
// trap with no operand flags
// immediate forms are the odd opcodes of each arithmetic row

`timescale 1ns/1ps
`default_nettype none

module opcode_table import mmix_decode_pkg::*; (
	input  logic [7:0] op,
	output op_class_e  op_class,
	output op_flags_t  flags
);

	op_class_e cls;
	op_flags_t f;
	logic      supported; // support column of the table
	logic      is_branch;

	// X written, Y and Z each either register or immediate
	function automatic op_flags_t arith_flags(input logic y_imm, input logic z_imm);
		op_flags_t fl;
		fl = '0;
		fl[FLAG_X_DEST] = 1'b1;
		if (y_imm)
			fl[FLAG_Y_IMM] = 1'b1;
		else
			fl[FLAG_Y_REG] = 1'b1;
		if (z_imm)
			fl[FLAG_Z_IMM] = 1'b1;
		else
			fl[FLAG_Z_REG] = 1'b1;
		return fl;
	endfunction

	assign is_branch = (op >= OP_BR_FIRST) && (op <= OP_BR_LAST);

	always_comb begin
		cls = cls_trap;
		f = '0;
		supported = 1'b0;
		if (is_branch) begin // BN .. PBEVB, backward forms odd
			supported = 1'b1;
			cls = op[4] ? cls_pbr : cls_br;
			f[FLAG_X_SRC] = 1'b1;
			f[FLAG_REL] = 1'b1;
		end else begin
			case (op[7:4])
				4'h2: if (!op[3]) begin // ADD ADDU SUB SUBU; 2ADDU.. not kept
					supported = 1'b1;
					f = arith_flags(1'b0, op[0]);
					case (op[2:1])
						2'b00:   cls = cls_add;
						2'b01:   cls = cls_addu;
						2'b10:   cls = cls_sub;
						default: cls = cls_subu;
					endcase
				end
				4'h3: begin
					supported = 1'b1;
					if (op[3]) begin // SL SLU SR SRU
						cls = op[2] ? cls_shr : cls_shl;
						f = arith_flags(1'b0, op[0]);
					end else if (!op[2]) begin // CMP CMPU
						cls = op[1] ? cls_cmpu : cls_cmp;
						f = arith_flags(1'b0, op[0]);
					end else begin // NEG NEGU, Y is an immediate
						cls = op[1] ? cls_subu : cls_sub;
						f = arith_flags(1'b1, op[0]);
					end
				end
				4'h6: begin // CSN .. CSEVI, old $X kept when false
					supported = 1'b1;
					cls = cls_cset;
					f = arith_flags(1'b0, op[0]);
					f[FLAG_X_SRC] = 1'b1;
				end
				4'hC: begin // OR ORN NOR XOR AND ANDN NAND NXOR
					supported = 1'b1;
					cls = cls_logic;
					f = arith_flags(1'b0, op[0]);
				end
				4'hE: begin // wyde rows, YZ is the immediate
					supported = 1'b1;
					f[FLAG_X_DEST] = 1'b1;
					if (op[3:2] == 2'b00) begin
						cls = cls_set; // SETH .. SETL ignore old $X
					end else begin
						cls = cls_wyde; // INC, OR, ANDN read $X
						f[FLAG_X_SRC] = 1'b1;
					end
				end
				4'hF: if (op[3:1] == 3'b000) begin // JMP JMPB
					supported = 1'b1;
					cls = cls_jmp;
					f[FLAG_REL] = 1'b1;
				end
				default: ; // float, mul/div, memory, special: trap
			endcase
		end
	end

	assign op_class = supported ? cls : cls_trap;
	assign flags    = supported ? f : op_flags_t'(0);

endmodule

`default_nettype wire

//--- logic/operand_spec_decoder.sv
// builds the Y, Z and b operand specifiers of one instruction
// registers at or above rg are global, all others local with slot = number
// relative targets are loc + 4*offset, the odd opcode marks a backward offset
// combinational, no state

`timescale 1ns/1ps
`default_nettype none

module operand_spec_decoder import mmix_decode_pkg::*; (
	input  inst_word_t inst,
	input  addr_t      loc,
	input  reg_num_t   rg,
	input  op_flags_t  flags,
	output spec_kind_e y_kind,
	output addr_t      y_val,
	output spec_kind_e z_kind,
	output addr_t      z_val,
	output spec_kind_e b_kind,
	output addr_t      b_val
);

	logic [7:0] op;
	reg_num_t   xx, yy, zz;
	logic       is_jmp, is_wyde;
	addr_t      rel_off; // byte offset, already times four
	addr_t      wyde_imm;

	function automatic spec_kind_e reg_kind(input reg_num_t r, input reg_num_t g);
		return (r >= g) ? kind_global : kind_local;
	endfunction

	function automatic addr_t reg_val(input reg_num_t r, input reg_num_t g);
		if (r >= g)
			return addr_t'(r);
		return addr_t'(r) & addr_t'(RING_SIZE - 1); // ring slot, O is always 0
	endfunction

	assign op = inst[31:24];
	assign xx = inst[23:16];
	assign yy = inst[15:8];
	assign zz = inst[7:0];

	assign is_jmp  = {op[7:1], 1'b0} == OP_JMP;
	assign is_wyde = op[7:4] == OP_WYDE_BASE[7:4];

	// op[0] doubles as the sign, giving offset - 2^24 or - 2^16
	assign rel_off = is_jmp ? {{38{op[0]}}, inst[23:0], 2'b00}
	                        : {{46{op[0]}}, inst[15:0], 2'b00};

	// shift 48, 32, 16, 0 for H, MH, ML, L
	assign wyde_imm = addr_t'(inst[15:0]) << {~op[1:0], 4'b0000};

	always_comb begin
		y_kind = kind_none;
		y_val = '0;
		z_kind = kind_none;
		z_val = '0;
		if (flags[FLAG_REL]) begin
			y_kind = kind_imm; // return / fall-through address
			y_val = loc + addr_t'(4);
			z_kind = kind_imm; // target
			z_val = loc + rel_off;
		end else if (is_wyde) begin
			z_kind = kind_imm;
			z_val = wyde_imm;
			if (op[3:2] != 2'b00) begin // not SET, $X is the other operand
				y_kind = reg_kind(xx, rg);
				y_val = reg_val(xx, rg);
			end
		end else begin
			if (flags[FLAG_Z_IMM]) begin
				z_kind = kind_imm;
				z_val = addr_t'(zz);
			end else if (flags[FLAG_Z_REG]) begin
				z_kind = reg_kind(zz, rg);
				z_val = reg_val(zz, rg);
			end
			if (flags[FLAG_Y_IMM]) begin
				y_kind = kind_imm;
				y_val = addr_t'(yy);
			end else if (flags[FLAG_Y_REG]) begin
				y_kind = reg_kind(yy, rg);
				y_val = reg_val(yy, rg);
			end
		end
	end

	// b carries old $X for branches, CS and the INC/OR/ANDN wydes
	assign b_kind = flags[FLAG_X_SRC] ? reg_kind(xx, rg) : kind_none;
	assign b_val  = flags[FLAG_X_SRC] ? reg_val(xx, rg) : addr_t'(0);

endmodule

`default_nettype wire

//--- logic/dest_allocator.sv
// destination of $X against the local window L, and L itself
// a marginal X (L <= X < rg) yields an interim incrl into slot L; the caller
// loads it without consuming, L steps up, and the same X is tried again
// no ring overflow handling: L must stay below rg
// decision is combinational, L changes only on an interim load

`timescale 1ns/1ps
`default_nettype none

module dest_allocator import mmix_decode_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  reg_num_t   rg,
	input  reg_num_t   xx,
	input  logic       x_dest, // FLAG_X_DEST of the opcode
	input  logic       load, // output stage takes the current command
	output logic       interim,
	output spec_kind_e x_kind,
	output reg_num_t   x_val,
	output reg_num_t   local_count
);

	reg_num_t local_l; // L, number of live locals

	always_comb begin
		interim = 1'b0;
		x_kind = kind_none;
		x_val = '0;
		if (x_dest) begin
			if (xx >= rg) begin
				x_kind = kind_global;
				x_val = xx;
			end else if (xx < local_l) begin
				x_kind = kind_local; // already inside the window
				x_val = xx & reg_num_t'(RING_SIZE - 1);
			end else begin
				// marginal, open slot L first
				interim = 1'b1;
				x_kind = kind_local;
				x_val = local_l & reg_num_t'(RING_SIZE - 1);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			local_l <= '0;
		else if (load && interim)
			local_l <= local_l + reg_num_t'(1);
	end

	assign local_count = local_l;

	// the window may not run into the globals, there is no gamma advance
	a_l_below_g: assert property (@(posedge clk) disable iff (!rst_n)
		local_l < rg)
		else $error("local count L reached global threshold G");

endmodule

`default_nettype wire

//--- logic/inst_decoder.sv
// one registered dispatch stage: instruction in, decoded command out
// valid/ready on both sides, result shows one cycle after the load edge
// upstream must hold in_inst/in_loc until in_ready, marginal X makes the
// stage emit incrl commands first without taking the instruction
// rg must not change while instructions are in flight

`timescale 1ns/1ps
`default_nettype none

module inst_decoder import mmix_decode_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  reg_num_t   rg, // global threshold G

	input  logic       in_valid,
	input  inst_word_t in_inst,
	input  addr_t      in_loc,
	output logic       in_ready,

	output logic       out_valid,
	input  logic       out_ready,
	output op_class_e  out_class,
	output logic       out_interim,
	output spec_kind_e out_x_kind,
	output reg_num_t   out_x_val,
	output spec_kind_e out_y_kind,
	output addr_t      out_y_val,
	output spec_kind_e out_z_kind,
	output addr_t      out_z_val,
	output spec_kind_e out_b_kind,
	output addr_t      out_b_val
);

	op_class_e  op_class;
	op_flags_t  op_flags;
	spec_kind_e y_kind, z_kind, b_kind, x_kind;
	addr_t      y_val, z_val, b_val;
	reg_num_t   x_val;
	reg_num_t   local_count;
	logic       dest_interim;
	logic       stage_free, load;

	assign stage_free = !out_valid || out_ready; // empty or draining this edge
	assign load       = in_valid && stage_free;
	assign in_ready   = stage_free && !dest_interim; // interim keeps the inst

	opcode_table opcode_table_inst (
		.op       (in_inst[31:24]),
		.op_class (op_class),
		.flags    (op_flags)
	);

	operand_spec_decoder operand_spec_decoder_inst (
		.inst   (in_inst),
		.loc    (in_loc),
		.rg     (rg),
		.flags  (op_flags),
		.y_kind (y_kind),
		.y_val  (y_val),
		.z_kind (z_kind),
		.z_val  (z_val),
		.b_kind (b_kind),
		.b_val  (b_val)
	);

	dest_allocator dest_allocator_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.rg          (rg),
		.xx          (in_inst[23:16]),
		.x_dest      (op_flags[FLAG_X_DEST]),
		.load        (load),
		.interim     (dest_interim),
		.x_kind      (x_kind),
		.x_val       (x_val),
		.local_count (local_count)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (stage_free)
			out_valid <= in_valid;
	end

	// payload, incrl carries only its destination
	always_ff @(posedge clk) begin
		if (load) begin
			out_class   <= dest_interim ? cls_incrl : op_class;
			out_interim <= dest_interim;
			out_x_kind  <= x_kind;
			out_x_val   <= x_val;
			out_y_kind  <= dest_interim ? kind_none : y_kind;
			out_y_val   <= dest_interim ? addr_t'(0) : y_val;
			out_z_kind  <= dest_interim ? kind_none : z_kind;
			out_z_val   <= dest_interim ? addr_t'(0) : z_val;
			out_b_kind  <= dest_interim ? kind_none : b_kind;
			out_b_val   <= dest_interim ? addr_t'(0) : b_val;
		end
	end

	// stalled command must not move
	a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_class) &&
		$stable(out_interim) && $stable(out_x_kind) && $stable(out_x_val) &&
		$stable(out_y_kind) && $stable(out_y_val) &&
		$stable(out_z_kind) && $stable(out_z_val) &&
		$stable(out_b_kind) && $stable(out_b_val))
		else $error("output changed under back-pressure");

	// an incrl lands in the old slot L and the window grows by one
	a_incrl_slot: assert property (@(posedge clk) disable iff (!rst_n)
		load && dest_interim |=> out_interim &&
		out_x_val == $past(local_count) &&
		local_count == reg_num_t'($past(local_count) + 8'd1))
		else $error("incrl destination out of step with L");

endmodule

`default_nettype wire

//--- tests/decode_expect.svh
// expected decode of one instruction, worked out from the decoder rules
// knows ADD/ADDI, the wyde rows, branches and JMP; anything else traps
// destination and incrl insertion are left to the caller, which tracks L
// included inside the testbench module, needs mmix_decode_pkg imported there
`ifndef DECODE_EXPECT_SVH
`define DECODE_EXPECT_SVH

typedef struct packed {
	op_class_e  cls;
	logic       interim;
	spec_kind_e x_kind;
	reg_num_t   x_val;
	spec_kind_e y_kind;
	addr_t      y_val;
	spec_kind_e z_kind;
	addr_t      z_val;
	spec_kind_e b_kind;
	addr_t      b_val;
} cmd_t;

// G and above are globals, below G the ring slot is the register number
function automatic spec_kind_e kind_of_reg(input reg_num_t r, input reg_num_t g);
	if (r < g)
		return kind_local;
	return kind_global;
endfunction

// opcodes whose X field names a destination
function automatic logic dest_expected(input logic [7:0] op);
	return (op == 8'h20) || (op == 8'h21) || (op >= 8'hE0 && op <= 8'hEF);
endfunction

// loc + 4 * signed offset, odd opcode means the offset runs backward
function automatic addr_t rel_target(input inst_word_t inst, input addr_t loc);
	longint off;
	if (inst[31:25] == 7'h78) begin // JMP, JMPB take all 24 bits
		off = longint'(inst[23:0]);
		if (inst[24])
			off = off - (longint'(1) << 24);
	end else begin
		off = longint'(inst[15:0]);
		if (inst[24])
			off = off - (longint'(1) << 16);
	end
	return loc + addr_t'(off * 4);
endfunction

function automatic cmd_t expect_cmd(input inst_word_t inst, input addr_t loc,
		input reg_num_t g);
	cmd_t c;
	logic [7:0] op;
	op = inst[31:24];
	c = '0; // trap, every kind none
	if (op == 8'h20 || op == 8'h21) begin
		c.cls = cls_add;
		c.y_kind = kind_of_reg(inst[15:8], g);
		c.y_val = addr_t'(inst[15:8]);
		c.z_kind = op[0] ? kind_imm : kind_of_reg(inst[7:0], g); // ADDI: Z is the byte
		c.z_val = addr_t'(inst[7:0]);
	end else if (op >= 8'hE0 && op <= 8'hEF) begin
		c.cls = (op < 8'hE4) ? cls_set : cls_wyde;
		c.z_kind = kind_imm;
		c.z_val = addr_t'(inst[15:0]) << (48 - 16 * int'(op[1:0])); // H MH ML L
		if (op >= 8'hE4) begin // INC, OR, ANDN also read $X
			c.y_kind = kind_of_reg(inst[23:16], g);
			c.y_val = addr_t'(inst[23:16]);
			c.b_kind = c.y_kind;
			c.b_val = c.y_val;
		end
	end else if ((op >= 8'h40 && op <= 8'h5F) || op == 8'hF0 || op == 8'hF1) begin
		c.cls = (op >= 8'hF0) ? cls_jmp : ((op >= 8'h50) ? cls_pbr : cls_br);
		c.y_kind = kind_imm;
		c.y_val = loc + addr_t'(4); // next instruction
		c.z_kind = kind_imm;
		c.z_val = rel_target(inst, loc);
		if (op < 8'hF0) begin // branch tests $X
			c.b_kind = kind_of_reg(inst[23:16], g);
			c.b_val = addr_t'(inst[23:16]);
		end
	end
	return c;
endfunction

`endif

//--- tests/tb_inst_decoder.sv
// directed tests for the dispatch decoder, G fixed at 32 for the whole run
// tests run back to back without reset, so L carries over between them
// inputs change on the falling edge, outputs are sampled a quarter cycle later

`timescale 1ns/1ps
`default_nettype none

module tb_inst_decoder import mmix_decode_pkg::*; ();

	localparam int       MAX_CYCLES = 2000; // tests need under 200 cycles
	localparam reg_num_t G = 8'd32;

	logic       clk, rst_n;
	reg_num_t   rg;
	logic       in_valid, in_ready, out_valid, out_ready, out_interim;
	inst_word_t in_inst;
	addr_t      in_loc, out_y_val, out_z_val, out_b_val;
	op_class_e  out_class;
	spec_kind_e out_x_kind, out_y_kind, out_z_kind, out_b_kind;
	reg_num_t   out_x_val;

	`include "decode_expect.svh"

	inst_word_t in_q[$]; // instructions of the current test
	addr_t      loc_q[$];
	cmd_t       exp_q[$]; // commands expected out, incrl included
	reg_num_t   model_l; // expected L
	int         cycles, errors, tests_run, tests_failed;

	inst_decoder inst_decoder_inst (
		.clk (clk), .rst_n (rst_n), .rg (rg),
		.in_valid (in_valid), .in_inst (in_inst), .in_loc (in_loc), .in_ready (in_ready),
		.out_valid (out_valid), .out_ready (out_ready), .out_class (out_class),
		.out_interim (out_interim), .out_x_kind (out_x_kind), .out_x_val (out_x_val),
		.out_y_kind (out_y_kind), .out_y_val (out_y_val), .out_z_kind (out_z_kind),
		.out_z_val (out_z_val), .out_b_kind (out_b_kind), .out_b_val (out_b_val)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: decoder stopped producing results after %0d cycles", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic string show(input cmd_t c);
		return $sformatf("cls=%0d int=%0b x=%0d/%0h y=%0d/%0h z=%0d/%0h b=%0d/%0h",
			c.cls, c.interim, c.x_kind, c.x_val, c.y_kind, c.y_val,
			c.z_kind, c.z_val, c.b_kind, c.b_val);
	endfunction

	// queue one instruction and the commands it should produce
	task automatic add_inst(input inst_word_t inst, input addr_t loc);
		cmd_t c;
		cmd_t inc;
		reg_num_t x;
		c = expect_cmd(inst, loc, G);
		x = inst[23:16];
		if (dest_expected(inst[31:24])) begin
			if (x >= G) begin
				c.x_kind = kind_global;
			end else begin
				while (model_l <= x) begin // marginal X, open slots L .. X first
					inc = '0;
					inc.cls = cls_incrl;
					inc.interim = 1'b1;
					inc.x_kind = kind_local;
					inc.x_val = model_l;
					exp_q.push_back(inc);
					model_l++;
				end
				c.x_kind = kind_local;
			end
			c.x_val = x;
		end
		exp_q.push_back(c);
		in_q.push_back(inst);
		loc_q.push_back(loc);
	endtask

	// stream the queued instructions through, stall adds back-pressure
	task automatic run_batch(input string name, input bit stall);
		cmd_t got_q[$];
		cmd_t now_out, held;
		bit   was_stalled, loaded;
		int   idx, hold, fails;
		idx = 0;
		fails = 0;
		was_stalled = 0;
		loaded = 0;
		hold = stall ? 6 : 0; // a solid stall first, random after
		while (got_q.size() < exp_q.size()) begin
			@(negedge clk);
			in_valid = (idx < in_q.size());
			if (idx < in_q.size()) begin
				in_inst = in_q[idx];
				in_loc = loc_q[idx];
			end
			if (hold > 0) begin
				out_ready = 1'b0;
				hold--;
			end else begin
				out_ready = stall ? 1'($urandom_range(0, 1)) : 1'b1;
			end
			#5;
			now_out = {out_class, out_interim, out_x_kind, out_x_val, out_y_kind, out_y_val,
				out_z_kind, out_z_val, out_b_kind, out_b_val};
			if (loaded && !out_valid) begin
				fails++;
				$display("%s: no result one cycle after the load edge", name);
			end
			if (was_stalled && (!out_valid || now_out !== held)) begin
				fails++;
				$display("%s: output moved while out_ready was low", name);
			end
			if (out_valid && !out_ready && in_ready) begin
				fails++;
				$display("%s: in_ready high while the stage is stalled", name);
			end
			was_stalled = out_valid && !out_ready;
			held = now_out;
			loaded = in_valid && (!out_valid || out_ready);
			if (out_valid && out_ready)
				got_q.push_back(now_out); // transfers on the next rising edge
			if (in_valid && in_ready)
				idx++;
		end
		for (int i = 0; i < exp_q.size(); i++) begin
			if (got_q[i] !== exp_q[i]) begin
				fails++;
				$display("error %s: command %0d expected %s actual %s", name, i,
					show(exp_q[i]), show(got_q[i]));
			end
		end
		$display("%s: %0d commands, %s", name, exp_q.size(), (fails == 0) ? "ok" : "FAILED");
		tests_run++;
		if (fails != 0)
			tests_failed++;
		errors += fails;
		in_q.delete();
		loc_q.delete();
		exp_q.delete();
	endtask

	task automatic test_global();
		add_inst({8'h20, 8'd40, 8'd41, 8'd42}, 64'h1000); // ADD $40,$41,$42
		run_batch("global operands", 0);
	endtask

	task automatic test_marginal();
		add_inst({8'h20, 8'd2, 8'd33, 8'd34}, 64'h1004); // L 0 -> 3
		add_inst({8'h20, 8'd1, 8'd33, 8'd34}, 64'h1008); // inside the window now
		run_batch("marginal X", 0);
	endtask

	task automatic test_immediates();
		add_inst({8'h21, 8'd1, 8'd3, 8'hA5}, 64'h1100); // ADDI
		add_inst({8'hE0, 8'd35, 16'h1234}, 64'h1104); // SETH
		add_inst({8'hE7, 8'd2, 16'hBEEF}, 64'h1108); // INCL
		run_batch("immediates and wydes", 0);
	endtask

	task automatic test_relative();
		add_inst({8'h42, 8'd5, 16'h0010}, 64'h2000); // BZ forward 16 words
		add_inst({8'h43, 8'd40, 16'hFFF0}, 64'h2004); // BZB back 16 words
		add_inst({8'hF0, 24'h000100}, 64'h2008); // JMP forward
		add_inst({8'hF1, 24'hFFFFFE}, 64'h200C); // JMPB back 2 words
		run_batch("relative addresses", 0);
	endtask

	task automatic test_unsupported();
		add_inst({8'h04, 8'd40, 8'd41, 8'd42}, 64'h3000); // FADD
		add_inst({8'h18, 8'd1, 8'd2, 8'd3}, 64'h3004); // MUL
		run_batch("unsupported opcodes", 0);
	endtask

	task automatic test_backpressure();
		for (int i = 0; i < 10; i++) begin
			if (i == 4)
				add_inst({8'h20, 8'd4, 8'd40, 8'd0}, 64'h4000 + addr_t'(4 * i)); // two incrl
			else
				add_inst({8'h20 | 8'($urandom_range(0, 1)), 8'($urandom_range(32, 255)),
					8'($urandom()), 8'($urandom())}, 64'h4000 + addr_t'(4 * i));
		end
		run_batch("back-pressure", 1);
	endtask

	initial begin
		void'($urandom(38));
		clk = 1'b0;
		rst_n = 1'b0;
		rg = G;
		in_valid = 1'b0;
		in_inst = '0;
		in_loc = '0;
		out_ready = 1'b0;
		cycles = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		model_l = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_global();
		test_marginal();
		test_immediates();
		test_relative();
		test_unsupported();
		test_backpressure();
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+tests
logic/mmix_decode_pkg.sv
logic/opcode_table.sv
logic/operand_spec_decoder.sv
logic/dest_allocator.sv
logic/inst_decoder.sv
tests/tb_inst_decoder.sv

//--- Makefile
# Verilator build of the dispatch decoder testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module tb_inst_decoder -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
